// ==== logic/kairo_pkg.sv ====
`default_nettype none

package kairo_pkg;

  ////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_num_t;
  typedef logic [15:0] ar_addr_t;
  typedef logic [10:0] op_sel_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // One bit per supported instruction
  localparam int OP_LUI    = 0;
  localparam int OP_ADDI   = 1;
  localparam int OP_ADD    = 2;
  localparam int OP_SUB    = 3;
  localparam int OP_AND    = 4;
  localparam int OP_OR     = 5;
  localparam int OP_XOR    = 6;
  localparam int OP_BEQ    = 7;
  localparam int OP_BNE    = 8;
  localparam int OP_JAL    = 9;
  localparam int OP_EBREAK = 10;

  ////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  localparam funct3_t F3_ADD = 3'b000;
  localparam funct3_t F3_XOR = 3'b100;
  localparam funct3_t F3_OR  = 3'b110;
  localparam funct3_t F3_AND = 3'b111;
  localparam funct3_t F3_BEQ = 3'b000;
  localparam funct3_t F3_BNE = 3'b001;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

  // EBREAK has funct12 of 1 and all other fields zero
  localparam logic [11:0] F12_EBREAK = 12'h001;

  ////////////////////////////////////////////////////////////////////
  // Boot and run control
  ////////////////////////////////////////////////////////////////////
  localparam word_t BOOT_ADDR   = 32'h0000_8000;
  localparam int    BOOT_CYCLES = 1;
  localparam int    BOOT_CNT_W  = $clog2(BOOT_CYCLES + 1);

  typedef logic [BOOT_CNT_W-1:0] boot_cnt_t;

  localparam boot_cnt_t BOOT_LAST = boot_cnt_t'(BOOT_CYCLES - 1);
  localparam boot_cnt_t BOOT_DONE = boot_cnt_t'(BOOT_CYCLES);

  localparam word_t      INST_STEP   = 32'd4;
  localparam logic [7:0] AR_REG_PAGE = 8'h10;

  typedef enum logic [1:0] {
    S_RESET,
    S_EXEC,
    S_HALT,
    S_RESUME
  } run_state_t;

endpackage

`default_nettype wire

// ==== logic/kairo_decode_if.sv ====
`default_nettype none

// Decoded instruction fields, combinational from the fetched word
interface kairo_decode_if;

  kairo_pkg::reg_num_t rs1_num;
  kairo_pkg::reg_num_t rs2_num;
  kairo_pkg::reg_num_t rd_num;
  kairo_pkg::word_t    imm;
  kairo_pkg::op_sel_t  op;

  modport decoder (
    output rs1_num,
    output rs2_num,
    output rd_num,
    output imm,
    output op
  );

  modport regfile (
    input rs1_num,
    input rs2_num
  );

  modport exec (
    input rd_num,
    input imm,
    input op
  );

endinterface

`default_nettype wire

// ==== logic/kairo_run_ctrl.sv ====
`default_nettype none

module kairo_run_ctrl (
  input  wire  CLK,
  input  wire  RST_N,
  input  wire  haltreq,
  input  wire  resumereq,
  input  wire  ebreak_retired,
  output logic issue,
  output logic halt,
  output logic resume,
  output logic running
);

  kairo_pkg::run_state_t state;
  kairo_pkg::run_state_t state_next;
  logic                  haltreq_q;

  // Halt request is taken one cycle late
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      haltreq_q <= 1'b0;
    end else begin
      haltreq_q <= haltreq;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Run state FSM
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      kairo_pkg::S_RESET: begin
        state_next = kairo_pkg::S_EXEC;
      end
      kairo_pkg::S_EXEC: begin
        // EBREAK retires on this same edge
        if (haltreq_q || ebreak_retired) begin
          state_next = kairo_pkg::S_HALT;
        end
      end
      kairo_pkg::S_HALT: begin
        if (resumereq) begin
          state_next = kairo_pkg::S_RESUME;
        end
      end
      kairo_pkg::S_RESUME: begin
        // Wait for the debugger to drop its request
        if (!resumereq) begin
          state_next = kairo_pkg::S_RESET;
        end
      end
      default: begin
        state_next = kairo_pkg::S_RESET;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= kairo_pkg::S_RESET;
    end else begin
      state <= state_next;
    end
  end

  // Level outputs
  assign issue   = (state == kairo_pkg::S_EXEC) && !haltreq_q;
  assign halt    = (state == kairo_pkg::S_HALT);
  assign resume  = (state == kairo_pkg::S_RESUME);
  assign running = (state == kairo_pkg::S_RESET) || (state == kairo_pkg::S_EXEC);

endmodule

`default_nettype wire

// ==== logic/kairo_pc_counter.sv ====
`default_nettype none

module kairo_pc_counter (
  input  wire              CLK,
  input  wire              RST_N,
  input  wire              retire,
  input  wire  kairo_pkg::word_t pc_next,
  output kairo_pkg::word_t pc,
  output logic             fetch_en
);

  kairo_pkg::boot_cnt_t boot_cnt;

  // Boot count saturates so a resume never reloads the boot address
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      boot_cnt <= '0;
      pc       <= '0;
      fetch_en <= 1'b0;
    end else if (boot_cnt != kairo_pkg::BOOT_DONE) begin
      boot_cnt <= boot_cnt + 1'b1;
      if (boot_cnt == kairo_pkg::BOOT_LAST) begin
        pc       <= kairo_pkg::BOOT_ADDR;
        fetch_en <= 1'b1;
      end
    end else if (retire) begin
      // Stalled cycles hold the PC
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== logic/kairo_decode.sv ====
`default_nettype none

module kairo_decode (
  input wire kairo_pkg::word_t inst,
  kairo_decode_if.decoder      dec
);

  kairo_pkg::opcode_t opcode;
  kairo_pkg::funct3_t funct3;
  kairo_pkg::funct7_t funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Register fields sit at fixed positions in every format
  assign dec.rs1_num = inst[19:15];
  assign dec.rs2_num = inst[24:20];
  assign dec.rd_num  = inst[11:7];

  ////////////////////////////////////////////////////////////////////
  // Immediate and op select
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    dec.imm = '0;
    dec.op  = '0;
    case (opcode)
      kairo_pkg::OPC_LUI: begin
        dec.imm = {inst[31:12], 12'b0};
        dec.op[kairo_pkg::OP_LUI] = 1'b1;
      end
      kairo_pkg::OPC_OP_IMM: begin
        dec.imm = {{20{inst[31]}}, inst[31:20]};
        if (funct3 == kairo_pkg::F3_ADD) begin
          dec.op[kairo_pkg::OP_ADDI] = 1'b1;
        end
      end
      kairo_pkg::OPC_OP: begin
        if (funct7 == kairo_pkg::F7_BASE) begin
          case (funct3)
            kairo_pkg::F3_ADD: dec.op[kairo_pkg::OP_ADD] = 1'b1;
            kairo_pkg::F3_XOR: dec.op[kairo_pkg::OP_XOR] = 1'b1;
            kairo_pkg::F3_OR:  dec.op[kairo_pkg::OP_OR]  = 1'b1;
            kairo_pkg::F3_AND: dec.op[kairo_pkg::OP_AND] = 1'b1;
            default: ;
          endcase
        end else if (funct7 == kairo_pkg::F7_ALT && funct3 == kairo_pkg::F3_ADD) begin
          dec.op[kairo_pkg::OP_SUB] = 1'b1;
        end
      end
      kairo_pkg::OPC_BRANCH: begin
        // B format
        dec.imm = {{19{inst[31]}}, inst[31], inst[7],
                   inst[30:25], inst[11:8], 1'b0};
        if (funct3 == kairo_pkg::F3_BEQ) begin
          dec.op[kairo_pkg::OP_BEQ] = 1'b1;
        end else if (funct3 == kairo_pkg::F3_BNE) begin
          dec.op[kairo_pkg::OP_BNE] = 1'b1;
        end
      end
      kairo_pkg::OPC_JAL: begin
        // J format
        dec.imm = {{11{inst[31]}}, inst[31], inst[19:12],
                   inst[20], inst[30:21], 1'b0};
        dec.op[kairo_pkg::OP_JAL] = 1'b1;
      end
      kairo_pkg::OPC_SYSTEM: begin
        if (inst[31:7] == {kairo_pkg::F12_EBREAK, 13'b0}) begin
          dec.op[kairo_pkg::OP_EBREAK] = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/kairo_exec.sv ====
`default_nettype none

module kairo_exec (
  input  wire                 issue,
  input  wire                 inst_ready,
  input  wire  kairo_pkg::word_t pc,
  input  wire  kairo_pkg::word_t rs1,
  input  wire  kairo_pkg::word_t rs2,
  kairo_decode_if.exec        dec,
  output logic                retire,
  output logic                ebreak_retired,
  output logic                rd_we,
  output kairo_pkg::reg_num_t rd_num,
  output kairo_pkg::word_t    rd_data,
  output kairo_pkg::word_t    pc_next
);

  kairo_pkg::word_t pc_plus;
  kairo_pkg::word_t target;
  kairo_pkg::word_t result;
  logic             has_rd;
  logic             taken;

  assign pc_plus = pc + kairo_pkg::INST_STEP;
  assign target  = pc + dec.imm;

  ////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    case (1'b1)
      dec.op[kairo_pkg::OP_LUI]:  result = dec.imm;
      dec.op[kairo_pkg::OP_ADDI]: result = rs1 + dec.imm;
      dec.op[kairo_pkg::OP_ADD]:  result = rs1 + rs2;
      dec.op[kairo_pkg::OP_SUB]:  result = rs1 - rs2;
      dec.op[kairo_pkg::OP_AND]:  result = rs1 & rs2;
      dec.op[kairo_pkg::OP_OR]:   result = rs1 | rs2;
      dec.op[kairo_pkg::OP_XOR]:  result = rs1 ^ rs2;
      // Link value
      dec.op[kairo_pkg::OP_JAL]:  result = pc_plus;
      default:                    result = '0;
    endcase
  end

  assign has_rd = dec.op[kairo_pkg::OP_LUI] | dec.op[kairo_pkg::OP_ADDI] |
                  dec.op[kairo_pkg::OP_ADD] | dec.op[kairo_pkg::OP_SUB] |
                  dec.op[kairo_pkg::OP_AND] | dec.op[kairo_pkg::OP_OR] |
                  dec.op[kairo_pkg::OP_XOR] | dec.op[kairo_pkg::OP_JAL];

  // Branch and jump resolution
  assign taken = (dec.op[kairo_pkg::OP_BEQ] && (rs1 == rs2)) ||
                 (dec.op[kairo_pkg::OP_BNE] && (rs1 != rs2)) ||
                 dec.op[kairo_pkg::OP_JAL];

  assign pc_next = taken ? target : pc_plus;

  // Unknown encodings retire as NOP
  assign retire         = issue & inst_ready;
  assign ebreak_retired = retire & dec.op[kairo_pkg::OP_EBREAK];
  assign rd_we          = retire & has_rd & (dec.rd_num != '0);
  assign rd_num         = dec.rd_num;
  assign rd_data        = result;

endmodule

`default_nettype wire

// ==== logic/kairo_regfile.sv ====
`default_nettype none

module kairo_regfile (
  input  wire                 CLK,
  input  wire                 RST_N,
  input  wire                 rd_we,
  input  wire  kairo_pkg::reg_num_t rd_num,
  input  wire  kairo_pkg::word_t    rd_data,
  input  wire                 dbg_en,
  input  wire                 dbg_wr,
  input  wire  kairo_pkg::ar_addr_t dbg_addr,
  input  wire  kairo_pkg::word_t    dbg_wdata,
  kairo_decode_if.regfile     dec,
  output kairo_pkg::word_t    rs1,
  output kairo_pkg::word_t    rs2,
  output kairo_pkg::word_t    dbg_rdata
);

  // x1 to x31 only
  kairo_pkg::word_t    regs [1:31];
  kairo_pkg::reg_num_t dbg_num;
  logic                dbg_hit;

  assign dbg_num = dbg_addr[4:0];
  assign dbg_hit = dbg_en & (dbg_addr[15:8] == kairo_pkg::AR_REG_PAGE);

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (rd_we && (rd_num != '0)) begin
        regs[rd_num] <= rd_data;
      end
      // Debug writes only happen while halted
      if (dbg_hit && dbg_wr && (dbg_num != '0)) begin
        regs[dbg_num] <= dbg_wdata;
      end
    end
  end

  // x0 reads as zero
  assign rs1       = (dec.rs1_num == '0) ? '0 : regs[dec.rs1_num];
  assign rs2       = (dec.rs2_num == '0) ? '0 : regs[dec.rs2_num];
  assign dbg_rdata = (!dbg_hit || (dbg_num == '0)) ? '0 : regs[dbg_num];

endmodule

`default_nettype wire

// ==== logic/kairo.sv ====
`default_nettype none

module kairo (
  input  wire                CLK,
  input  wire                RST_N,
  // Instruction fetch
  output logic               i_mem_valid,
  output kairo_pkg::word_t   i_mem_addr,
  input  wire                i_mem_ready,
  input  wire  kairo_pkg::word_t i_mem_rdata,
  // Run control
  input  wire                haltreq,
  input  wire                resumereq,
  output logic               halt,
  output logic               resume,
  output logic               running,
  // Register access
  input  wire                ar_en,
  input  wire                ar_wr,
  input  wire  kairo_pkg::ar_addr_t ar_ad,
  input  wire  kairo_pkg::word_t    ar_di,
  output kairo_pkg::word_t   ar_do
);

  logic             issue;
  logic             retire;
  logic             ebreak_retired;
  logic             fetch_en;
  logic             rd_we;
  kairo_pkg::reg_num_t rd_num;
  kairo_pkg::word_t rd_data;
  kairo_pkg::word_t pc;
  kairo_pkg::word_t pc_next;
  kairo_pkg::word_t rs1;
  kairo_pkg::word_t rs2;

  kairo_decode_if dec_if ();

  ////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////
  kairo_run_ctrl u_run_ctrl (
    .CLK            (CLK),
    .RST_N          (RST_N),
    .haltreq        (haltreq),
    .resumereq      (resumereq),
    .ebreak_retired (ebreak_retired),
    .issue          (issue),
    .halt           (halt),
    .resume         (resume),
    .running        (running)
  );

  kairo_pc_counter u_pc_counter (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .retire   (retire),
    .pc_next  (pc_next),
    .pc       (pc),
    .fetch_en (fetch_en)
  );

  // Fetch once booted and not halted
  assign i_mem_valid = fetch_en & running;
  assign i_mem_addr  = pc;

  ////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////
  kairo_decode u_decode (
    .inst (i_mem_rdata),
    .dec  (dec_if.decoder)
  );

  kairo_regfile u_regfile (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .rd_we     (rd_we),
    .rd_num    (rd_num),
    .rd_data   (rd_data),
    .dbg_en    (ar_en & halt),
    .dbg_wr    (ar_wr),
    .dbg_addr  (ar_ad),
    .dbg_wdata (ar_di),
    .dec       (dec_if.regfile),
    .rs1       (rs1),
    .rs2       (rs2),
    .dbg_rdata (ar_do)
  );

  kairo_exec u_exec (
    .issue          (issue),
    .inst_ready     (i_mem_ready),
    .pc             (pc),
    .rs1            (rs1),
    .rs2            (rs2),
    .dec            (dec_if.exec),
    .retire         (retire),
    .ebreak_retired (ebreak_retired),
    .rd_we          (rd_we),
    .rd_num         (rd_num),
    .rd_data        (rd_data),
    .pc_next        (pc_next)
  );

endmodule

`default_nettype wire

// ==== bench/kairo_clock_gen.sv ====
`default_nettype none

module kairo_clock_gen (
  input  wire  restart,
  output logic CLK,
  output logic RST_N
);

  int rst_cnt = 0;

  initial begin
    CLK   = 1'b0;
    RST_N = 1'b0;
  end

  always #2 CLK = ~CLK;

  // Reset low for three rising edges, and again after each restart
  always @(posedge CLK) begin
    if (restart) begin
      rst_cnt <= 0;
      RST_N   <= 1'b0;
    end else if (rst_cnt < 3) begin
      rst_cnt <= rst_cnt + 1;
      RST_N   <= (rst_cnt == 2);
    end
  end

endmodule

`default_nettype wire

// ==== bench/kairo_assertions.sv ====
`default_nettype none

module kairo_assertions (
  input wire                   CLK,
  input wire                   RST_N,
  input wire                   halt,
  input wire                   resume,
  input wire                   running,
  input wire                   i_mem_valid,
  input wire kairo_pkg::word_t i_mem_addr
);

  int fail_count = 0;

  // Run levels never overlap
  a_halt_running: assert property (@(posedge CLK) disable iff (!RST_N)
    !(halt && running))
    else begin
      $error("halt and running are high together");
      fail_count++;
    end

  a_resume_halt: assert property (@(posedge CLK) disable iff (!RST_N)
    !(resume && halt))
    else begin
      $error("resume is high while halted");
      fail_count++;
    end

  a_fetch_running: assert property (@(posedge CLK) disable iff (!RST_N)
    i_mem_valid |-> running)
    else begin
      $error("fetch is valid while the core is not running");
      fail_count++;
    end

  // Fetch address stays word aligned
  a_addr_aligned: assert property (@(posedge CLK) disable iff (!RST_N)
    (i_mem_addr % kairo_pkg::INST_STEP) == '0)
    else begin
      $error("fetch address %h is not aligned", i_mem_addr);
      fail_count++;
    end

endmodule

bind kairo kairo_assertions u_assertions (
  .CLK         (CLK),
  .RST_N       (RST_N),
  .halt        (halt),
  .resume      (resume),
  .running     (running),
  .i_mem_valid (i_mem_valid),
  .i_mem_addr  (i_mem_addr)
);

`default_nettype wire

// ==== bench/kairo_tb.sv ====
`default_nettype none

module kairo_tb;

  // Word offsets into the data file
  localparam int TDATA_WORDS = 96;
  localparam int IMEM_WORDS  = 16;
  localparam int OFS_ARITH   = 'h00;
  localparam int OFS_CTRL    = 'h10;
  localparam int OFS_DBG     = 'h20;
  localparam int OFS_LOOP    = 'h28;
  localparam int OFS_LEN     = 'h30;
  localparam int OFS_READY   = 'h34;
  localparam int OFS_DVAL    = 'h35;
  localparam int OFS_EXP     = 'h40;
  localparam int HALT_BOUND  = 4;

  logic                CLK;
  logic                RST_N;
  logic                restart;
  logic                i_mem_valid;
  kairo_pkg::word_t    i_mem_addr;
  logic                i_mem_ready;
  kairo_pkg::word_t    i_mem_rdata;
  logic                haltreq;
  logic                resumereq;
  logic                halt;
  logic                resume;
  logic                running;
  logic                ar_en;
  logic                ar_wr;
  kairo_pkg::ar_addr_t ar_ad;
  kairo_pkg::word_t    ar_di;
  kairo_pkg::word_t    ar_do;

  kairo_pkg::word_t tdata [0:TDATA_WORDS-1];
  kairo_pkg::word_t imem  [0:IMEM_WORDS-1];
  kairo_pkg::word_t word_idx;
  int               prog_len;
  logic             stall_on;
  logic             watch_on;
  string            waiting_for;
  int               cyc;
  int               watch_cnt;
  int               limit;
  int               errors;
  int               tests;
  int               failed_tests;

  kairo_clock_gen u_clock_gen (
    .restart (restart),
    .CLK     (CLK),
    .RST_N   (RST_N)
  );

  kairo i_kairo (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .i_mem_valid (i_mem_valid),
    .i_mem_addr  (i_mem_addr),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata),
    .haltreq     (haltreq),
    .resumereq   (resumereq),
    .halt        (halt),
    .resume      (resume),
    .running     (running),
    .ar_en       (ar_en),
    .ar_wr       (ar_wr),
    .ar_ad       (ar_ad),
    .ar_di       (ar_di),
    .ar_do       (ar_do)
  );

  ////////////////////////////////////////////////////////////////////
  // Instruction memory model
  ////////////////////////////////////////////////////////////////////
  // Unloaded words decode as NOPs that carry their own address
  function automatic kairo_pkg::word_t unloaded_word(input kairo_pkg::word_t addr);
    return {addr[31:7] ^ 25'(addr[6:0]), 7'b0000000};
  endfunction

  // Same-cycle answer from the loaded program
  assign word_idx    = (i_mem_addr - kairo_pkg::BOOT_ADDR) >> 2;
  assign i_mem_rdata = (word_idx < prog_len) ? imem[word_idx] : unloaded_word(i_mem_addr);

  // Ready pattern indexed by cycles since reset
  always @(posedge CLK) begin
    if (!RST_N) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
    i_mem_ready <= stall_on ? tdata[OFS_READY][cyc % 32] : 1'b1;
  end

  // Watchdog on every wait for the core
  always @(posedge CLK) begin
    if (!watch_on) begin
      watch_cnt <= 0;
    end else begin
      watch_cnt <= watch_cnt + 1;
      if (watch_cnt >= limit) begin
        $display("Timeout: the core never reached %s within %0d cycles", waiting_for, limit);
        $display(">>> FAIL");
        $finish;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Tasks
  ////////////////////////////////////////////////////////////////////
  task automatic check(input string name, input kairo_pkg::word_t got,
                       input kairo_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string title, input int mark);
    tests++;
    if (errors == mark) begin
      $display("test %0d %s: ok", tests, title);
    end else begin
      failed_tests++;
      $display("test %0d %s: failed with %0d mismatches", tests, title, errors - mark);
    end
  endtask

  // Reload the image and reset the core
  task automatic start_program(input int ofs, input int len, input logic stall);
    @(posedge CLK);
    restart <= 1'b1;
    @(posedge CLK);
    restart <= 1'b0;
    prog_len = len;
    for (int i = 0; i < len; i++) begin
      imem[i] = tdata[ofs + i];
    end
    stall_on = stall;
    limit    = len * 4 + (stall ? 32 - $countones(tdata[OFS_READY]) : 0) + 50;
    @(negedge CLK);
    while (!RST_N) @(negedge CLK);
  endtask

  task automatic wait_for_state(input logic on_resume);
    waiting_for = on_resume ? "resume" : "halt";
    @(negedge CLK);
    watch_on = 1'b1;
    while (!(on_resume ? resume : halt)) @(negedge CLK);
    watch_on = 1'b0;
  endtask

  task automatic debug_access(input logic wr, input logic [7:0] page,
                              input kairo_pkg::reg_num_t num,
                              input kairo_pkg::word_t wdata,
                              output kairo_pkg::word_t rdata);
    @(posedge CLK);
    ar_en <= 1'b1;
    ar_wr <= wr;
    ar_ad <= {page, 3'b000, num};
    ar_di <= wdata;
    @(negedge CLK);
    rdata = ar_do;
    @(posedge CLK);
    ar_en <= 1'b0;
    ar_wr <= 1'b0;
  endtask

  task automatic check_regs(input int exp_base);
    kairo_pkg::word_t val;
    for (int i = 0; i < 8; i++) begin
      debug_access(1'b0, kairo_pkg::AR_REG_PAGE, kairo_pkg::reg_num_t'(i), '0, val);
      check($sformatf("x%0d", i), val, tdata[exp_base + i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////
  initial begin
    kairo_pkg::word_t val;
    int               mark;
    int               n;
    restart      = 1'b0;
    haltreq      = 1'b0;
    resumereq    = 1'b0;
    ar_en        = 1'b0;
    ar_wr        = 1'b0;
    ar_ad        = '0;
    ar_di        = '0;
    i_mem_ready  = 1'b0;
    prog_len     = 0;
    stall_on     = 1'b0;
    watch_on     = 1'b0;
    waiting_for  = "boot";
    limit        = 100;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    $readmemh("bench/kairo_testdata.hex", tdata);

    // Boot, then the arithmetic program
    mark = errors;
    start_program(OFS_ARITH, tdata[OFS_LEN], 1'b0);
    // First cycle after reset release
    check("running", running, 32'd1);
    check("i_mem_valid", i_mem_valid, '0);
    check("halt", halt, '0);
    check("resume", resume, '0);
    waiting_for = "first fetch";
    watch_on    = 1'b1;
    while (!i_mem_valid) @(negedge CLK);
    watch_on = 1'b0;
    check("i_mem_addr", i_mem_addr, kairo_pkg::BOOT_ADDR);
    report_test("boot", mark);
    mark = errors;
    wait_for_state(1'b0);
    check_regs(OFS_EXP);
    report_test("arithmetic", mark);

    mark = errors;
    start_program(OFS_CTRL, tdata[OFS_LEN + 1], 1'b0);
    wait_for_state(1'b0);
    check_regs(OFS_EXP + 8);
    report_test("control flow", mark);

    // Same program under back-pressure
    mark = errors;
    start_program(OFS_ARITH, tdata[OFS_LEN], 1'b1);
    wait_for_state(1'b0);
    check_regs(OFS_EXP);
    report_test("stall", mark);

    mark = errors;
    start_program(OFS_DBG, tdata[OFS_LEN + 2], 1'b0);
    wait_for_state(1'b0);
    debug_access(1'b1, kairo_pkg::AR_REG_PAGE, 5'd3, tdata[OFS_DVAL], val);
    debug_access(1'b1, kairo_pkg::AR_REG_PAGE + 8'd1, 5'd4, tdata[OFS_DVAL], val);
    check("ar_do", val, '0);
    debug_access(1'b0, kairo_pkg::AR_REG_PAGE + 8'd1, 5'd3, '0, val);
    check("ar_do", val, '0);
    @(posedge CLK);
    resumereq <= 1'b1;
    wait_for_state(1'b1);
    @(posedge CLK);
    resumereq <= 1'b0;
    wait_for_state(1'b0);
    check_regs(OFS_EXP + 16);
    report_test("debug write and resume", mark);

    // Endless loop stopped by a halt request
    mark = errors;
    start_program(OFS_LOOP, tdata[OFS_LEN + 3], 1'b0);
    repeat (6) @(negedge CLK);
    debug_access(1'b0, kairo_pkg::AR_REG_PAGE, 5'd1, '0, val);
    check("ar_do", val, '0);
    @(posedge CLK);
    haltreq <= 1'b1;
    n = 0;
    @(negedge CLK);
    while (!halt && n < HALT_BOUND) begin
      n++;
      @(negedge CLK);
    end
    if (!halt) begin
      $display("halt did not rise within %0d cycles of the halt request", HALT_BOUND);
      errors++;
    end
    check("running", running, '0);
    check("i_mem_addr", i_mem_addr, kairo_pkg::BOOT_ADDR + kairo_pkg::INST_STEP);
    @(posedge CLK);
    haltreq <= 1'b0;
    check_regs(OFS_EXP + 24);
    report_test("halt request", mark);

    $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
             tests, failed_tests, errors, i_kairo.u_assertions.fail_count);
    if (errors == 0 && failed_tests == 0 && i_kairo.u_assertions.fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/kairo_testdata.hex ====
// One 32-bit word per column. @00 arithmetic, @10 control flow, @20 debug resume, @28 loop
// programs; @30 lengths; @34 ready pattern and debug value; @40 expected x0..x7 per test
@00
123450B7 67808093 FFF00113 002081B3 40208233
0030F2B3 0041E333 0020C3B3 00508013 00100073
@10
00100093 00100113 00208463 7FF00193 00209463 00400213
00009463 7FF00293 00008463 0080036F 7FF00393 00100073
@20
01000093 00100073 00308133 00100073
@28
00100093 00009063
// Program lengths in words
@30
0000000A 0000000C 00000004 00000002
// Ready bit per cycle, then the debug write value
@34
ED6B5B77 A5A50F0F
// Expected x0..x7 for arithmetic, control flow, debug resume and halt request
@40
00000000 12345678 FFFFFFFF 12345677 12345679 12345670 1234567F EDCBA987
@48
00000000 00000001 00000001 00000000 00000004 00000000 00008028 00000000
@50
00000000 00000010 A5A50F1F A5A50F0F 00000000 00000000 00000000 00000000
@58
00000000 00000001 00000000 00000000 00000000 00000000 00000000 00000000

// ==== kairo.f ====
logic/kairo_pkg.sv
logic/kairo_decode_if.sv
logic/kairo_run_ctrl.sv
logic/kairo_pc_counter.sv
logic/kairo_decode.sv
logic/kairo_exec.sv
logic/kairo_regfile.sv
logic/kairo.sv
bench/kairo_clock_gen.sv
bench/kairo_assertions.sv
bench/kairo_tb.sv

// ==== Bender.yml ====
package:
  name: kairo

sources:
  - files:
      - logic/kairo_pkg.sv
      - logic/kairo_decode_if.sv
      - logic/kairo_run_ctrl.sv
      - logic/kairo_pc_counter.sv
      - logic/kairo_decode.sv
      - logic/kairo_exec.sv
      - logic/kairo_regfile.sv
      - logic/kairo.sv
  - target: test
    files:
      - bench/kairo_clock_gen.sv
      - bench/kairo_assertions.sv
      - bench/kairo_tb.sv
